// ==== verilog.f ====
logic/yolo_cfg_pkg.sv
logic/yolo_types_pkg.sv
logic/shadow_if.sv
logic/cfg_regs.sv
logic/cfg_shadow_pipe.sv
logic/cfg_shadow.sv
logic/ext_addr_calc.sv
logic/wr_addrgen.sv
logic/acc_sequencer.sv
logic/yolo_write_ctrl.sv
verif/tb_yolo_write_ctrl.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the yolo_write_ctrl testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
   -f verilog.f \
   --top-module tb_yolo_write_ctrl \
   -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
   exit 1
fi
exit 0

// ==== verif/tb_yolo_write_ctrl.sv ====
`timescale 1ns/100ps

module tb_yolo_write_ctrl;

   import yolo_cfg_pkg::*;

   // bounds of the random sequence fields
   localparam int max_delay   = 7;
   localparam int max_iter    = 4;
   localparam int max_per     = 7;
   localparam int max_seq     = max_delay + max_iter * max_per + 3;
   localparam int n_runs      = 20;
   localparam int n_writes    = 40;
   localparam int cycle_limit = 3 + n_runs * (max_seq + 5) + 2 * n_writes + 50;

   logic                                clk;
   logic                                rst;
   logic                                valid;
   logic                                wstrb;
   logic [cfg_addr_w-1:0]               addr;
   logic [io_addr_w-1:0]                wdata;
   logic                                clear;
   logic                                run;
   logic [n_stages-1:0][io_addr_w-1:0]  stage_ext_addr;
   logic [mem_addr_w-1:0]               int_addr;
   logic [mem_addr_w-1:0]               wr_addr;
   logic                                wr_en;
   logic                                ld_acc;
   logic                                ld_mp;
   logic                                ld_res;
   logic                                done;

   // reference model state
   logic [31:0]           m_reg [16];
   logic [31:0]           m_sh0 [16];
   logic [31:0]           m_sh1 [16];
   logic [mem_addr_w-1:0] m_int0;
   logic [mem_addr_w-1:0] m_int1;

   logic [15:0] lfsr;
   int          n_checks;
   int          n_errors;
   int          cycles;

   yolo_write_ctrl DUT (
      .clk            (clk),
      .rst            (rst),
      .valid          (valid),
      .wstrb          (wstrb),
      .addr           (addr),
      .wdata          (wdata),
      .clear          (clear),
      .run            (run),
      .stage_ext_addr (stage_ext_addr),
      .int_addr       (int_addr),
      .wr_addr        (wr_addr),
      .wr_en          (wr_en),
      .ld_acc         (ld_acc),
      .ld_mp          (ld_mp),
      .ld_res         (ld_res),
      .done           (done)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   initial begin
      cycles = 0;
      while (cycles < cycle_limit) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout: the run did not finish within %0d clock cycles", cycle_limit);
      $display("SOME TESTS FAILED");
      $finish;
   end

   task automatic check_val(input string name, input logic [31:0] got,
                            input logic [31:0] expected);
      n_checks++;
      if (got !== expected) begin
         n_errors++;
         $display("Mismatch %s: got %h expected %h at %0t", name, got, expected, $time);
      end
   endtask

   // galois lfsr stepped once per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      logic        b;
      v = '0;
      for (int i = 0; i < n; i++) begin
         b    = lfsr[0];
         lfsr = {1'b0, lfsr[15:1]};
         if (b) begin
            lfsr = lfsr ^ 16'hb400;
         end
         v = {v[30:0], b};
      end
      return v;
   endfunction

   function automatic logic [31:0] field_mask(input logic [cfg_addr_w-1:0] a);
      case (a)
         cfg_ext_base:    return 32'hffff_ffff;
         cfg_ext_offset:  return 32'h0000_ffff;
         cfg_acc_maxpool: return 32'h1;
         cfg_acc_bypass:  return 32'h1;
         default:         return 32'h3ff;
      endcase
   endfunction

   task automatic write_reg(input logic [cfg_addr_w-1:0] a, input logic [31:0] d,
                            input logic strobe);
      @(negedge clk);
      valid = 1'b1;
      wstrb = strobe;
      addr  = a;
      wdata = d;
      if (strobe) begin
         m_reg[a] = d & field_mask(a);
      end
      @(negedge clk);
      valid = 1'b0;
      wstrb = 1'b0;
   endtask

   // ld_acc comes one cycle into each period
   function automatic logic acc_pulse(input int c, input int iter, input int per);
      return (c >= 1) && ((c - 1) % per == 0) && ((c - 1) / per < iter);
   endfunction

   task automatic run_and_check();
      int          c;
      int          k;
      int          mp;
      int          wp;
      int          ap;
      int          wi;
      int          ai;
      int          wdly;
      int          wr_len;
      int          acc_len;
      int          tot;
      logic        exp_res;
      logic [31:0] exp_addr;
      @(negedge clk);
      run = 1'b1;
      for (int i = 0; i < 16; i++) begin
         m_sh1[i] = m_sh0[i];
         m_sh0[i] = m_reg[i];
      end
      // top bit flips when the external side is active
      m_int1 = m_int0;
      m_int0 = {m_int0[mem_addr_w-1] ^ (m_reg[cfg_ext_iter] != 0),
                m_reg[cfg_int_addr][mem_addr_w-2:0]};
      @(negedge clk);
      run = 1'b0;

      wi      = m_sh1[cfg_wr_iter];
      wp      = (m_sh1[cfg_wr_per] == 0) ? 1 : m_sh1[cfg_wr_per];
      wdly    = m_sh1[cfg_wr_delay];
      wr_len  = (wi == 0) ? 0 : wdly + wi * wp;
      ai      = m_sh1[cfg_acc_iter];
      ap      = (m_sh1[cfg_acc_per] == 0) ? 1 : m_sh1[cfg_acc_per];
      acc_len = (ai == 0) ? 0 : ((ai * ap > (ai - 1) * ap + 3) ? ai * ap : (ai - 1) * ap + 3);
      tot     = (wr_len > acc_len) ? wr_len : acc_len;

      mp = 2;
      c  = 0;
      @(negedge clk);
      while (1'b1) begin
         if (c < wr_len && c >= wdly) begin
            k        = c - wdly;
            exp_addr = (m_sh1[cfg_wr_start] + (k / wp) * m_sh1[cfg_wr_shift]
                        + (k % wp) * m_sh1[cfg_wr_incr]) & 32'h3ff;
            check_val("wr_addr", wr_addr, exp_addr);
            check_val("wr_en", wr_en, (k % wp) < m_sh1[cfg_wr_duty]);
         end else begin
            check_val("wr_en", wr_en, 1'b0);
         end
         exp_res = acc_pulse(c - 1, ai, ap) | (m_sh1[cfg_acc_bypass][0] && c < acc_len);
         check_val("ld_acc", ld_acc, acc_pulse(c, ai, ap));
         check_val("ld_res", ld_res, exp_res);
         check_val("ld_mp", ld_mp, m_sh1[cfg_acc_maxpool][0] && mp != 0 && c < acc_len);
         if (exp_res) begin
            mp = (mp + 1) % 4;
         end
         if (done === 1'b1) begin
            break;
         end
         c++;
         @(negedge clk);
      end
      check_val("sequence length", c, tot);

      // external addresses settle two cycles after the shadow
      repeat (2) @(negedge clk);
      check_val("int_addr", int_addr, m_int1);
      for (int i = 0; i < n_stages; i++) begin
         check_val($sformatf("stage_ext_addr[%0d]", i), stage_ext_addr[i],
                   m_sh1[cfg_ext_base] + i * m_sh1[cfg_ext_offset]);
      end
   endtask

   initial begin
      rst      = 1'b1;
      valid    = 1'b0;
      wstrb    = 1'b0;
      addr     = '0;
      wdata    = '0;
      clear    = 1'b0;
      run      = 1'b0;
      lfsr     = 16'd6717;
      n_checks = 0;
      n_errors = 0;
      m_int0   = '0;
      m_int1   = '0;
      for (int i = 0; i < 16; i++) begin
         m_reg[i] = '0;
         m_sh0[i] = '0;
         m_sh1[i] = '0;
      end
      repeat (3) @(negedge clk);
      rst = 1'b0;

      // idle state after reset
      @(negedge clk);
      check_val("done", done, 1'b1);
      check_val("wr_en", wr_en, 1'b0);
      check_val("ld_acc", ld_acc, 1'b0);
      check_val("ld_mp", ld_mp, 1'b0);
      check_val("ld_res", ld_res, 1'b0);
      check_val("int_addr", int_addr, '0);
      check_val("wr_addr", wr_addr, '0);
      for (int i = 0; i < n_stages; i++) begin
         check_val($sformatf("stage_ext_addr[%0d]", i), stage_ext_addr[i], '0);
      end

      // stage addresses and a write without strobe
      write_reg(cfg_ext_base, rand_bits(32), 1'b1);
      write_reg(cfg_ext_offset, rand_bits(16), 1'b1);
      write_reg(cfg_ext_base, rand_bits(32), 1'b0);
      run_and_check();
      run_and_check();

      // write sequences
      for (int t = 0; t < 3; t++) begin
         write_reg(cfg_wr_start, rand_bits(10), 1'b1);
         write_reg(cfg_wr_iter, rand_bits(2) + 1, 1'b1);
         write_reg(cfg_wr_per, rand_bits(3), 1'b1);
         write_reg(cfg_wr_duty, rand_bits(3), 1'b1);
         write_reg(cfg_wr_shift, rand_bits(10), 1'b1);
         write_reg(cfg_wr_incr, rand_bits(10), 1'b1);
         write_reg(cfg_wr_delay, rand_bits(3), 1'b1);
         run_and_check();
         run_and_check();
      end

      // ping-pong toggles three times, holds at one and toggles back
      write_reg(cfg_ext_iter, rand_bits(4) + 1, 1'b1);
      write_reg(cfg_int_addr, rand_bits(10), 1'b1);
      repeat (3) run_and_check();
      write_reg(cfg_ext_iter, 32'd0, 1'b1);
      repeat (2) run_and_check();
      write_reg(cfg_ext_iter, rand_bits(4) + 1, 1'b1);
      run_and_check();
      write_reg(cfg_ext_iter, 32'd0, 1'b1);

      // accumulate with max-pool, then with bypass
      write_reg(cfg_acc_iter, rand_bits(2) + 1, 1'b1);
      write_reg(cfg_acc_per, rand_bits(3), 1'b1);
      write_reg(cfg_acc_maxpool, 32'd1, 1'b1);
      run_and_check();
      run_and_check();
      write_reg(cfg_acc_iter, rand_bits(2) + 1, 1'b1);
      write_reg(cfg_acc_per, rand_bits(3), 1'b1);
      write_reg(cfg_acc_bypass, 32'd1, 1'b1);
      run_and_check();
      run_and_check();

      // clear wipes every register
      @(negedge clk);
      clear = 1'b1;
      for (int i = 0; i < 16; i++) begin
         m_reg[i] = '0;
      end
      @(negedge clk);
      clear = 1'b0;
      run_and_check();
      run_and_check();
      check_val("wr_addr", wr_addr, '0);
      check_val("int_addr", int_addr, '0);
      check_val("done", done, 1'b1);

      $display("%0d checks, %0d mismatches", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

// ==== logic/yolo_write_ctrl.sv ====
`timescale 1ns/100ps

module yolo_write_ctrl (
   input  logic                                clk,
   input  logic                                rst,
   input  logic                                valid,
   input  logic                                wstrb,
   input  logic [yolo_cfg_pkg::cfg_addr_w-1:0] addr,
   input  logic [yolo_cfg_pkg::io_addr_w-1:0]  wdata,
   input  logic                                clear,
   input  logic                                run,
   output logic [yolo_cfg_pkg::n_stages-1:0][yolo_cfg_pkg::io_addr_w-1:0] stage_ext_addr,
   output logic [yolo_cfg_pkg::mem_addr_w-1:0] int_addr,
   output logic [yolo_cfg_pkg::mem_addr_w-1:0] wr_addr,
   output logic                                wr_en,
   output logic                                ld_acc,
   output logic                                ld_mp,
   output logic                                ld_res,
   output logic                                done
);

   import yolo_cfg_pkg::*;
   import yolo_types_pkg::*;

   ext_cfg_t              reg_ext_cfg;
   logic [mem_addr_w-1:0] reg_int_addr;
   wr_cfg_t               reg_wr_cfg;
   acc_cfg_t              reg_acc_cfg;
   logic                  wr_done;
   logic                  acc_done;

   shadow_if sh ();

   cfg_regs u_regs (
      .clk      (clk),
      .rst      (rst),
      .clear    (clear),
      .valid    (valid),
      .wstrb    (wstrb),
      .addr     (addr),
      .wdata    (wdata),
      .ext_cfg  (reg_ext_cfg),
      .int_addr (reg_int_addr),
      .wr_cfg   (reg_wr_cfg),
      .acc_cfg  (reg_acc_cfg)
   );

   cfg_shadow u_shadow (
      .clk      (clk),
      .rst      (rst),
      .run      (run),
      .ext_cfg  (reg_ext_cfg),
      .int_addr (reg_int_addr),
      .wr_cfg   (reg_wr_cfg),
      .acc_cfg  (reg_acc_cfg),
      .sh       (sh.src)
   );

   ext_addr_calc u_ext_addr (
      .clk            (clk),
      .rst            (rst),
      .sh             (sh.ext_sink),
      .stage_ext_addr (stage_ext_addr)
   );

   wr_addrgen u_wr_addrgen (
      .clk  (clk),
      .rst  (rst),
      .sh   (sh.seq_sink),
      .addr (wr_addr),
      .en   (wr_en),
      .done (wr_done)
   );

   acc_sequencer u_acc_seq (
      .clk    (clk),
      .rst    (rst),
      .sh     (sh.seq_sink),
      .ld_acc (ld_acc),
      .ld_mp  (ld_mp),
      .ld_res (ld_res),
      .done   (acc_done)
   );

   assign int_addr = sh.int_addr;
   assign done     = wr_done & acc_done;

endmodule

// ==== logic/acc_sequencer.sv ====
`timescale 1ns/100ps

module acc_sequencer (
   input  logic       clk,
   input  logic       rst,
   shadow_if.seq_sink sh,
   output logic       ld_acc,
   output logic       ld_mp,
   output logic       ld_res,
   output logic       done
);

   import yolo_cfg_pkg::*;

   logic                  walking;
   logic [period_w-1:0]   p;
   logic [mem_addr_w-1:0] it;
   logic                  ld_acc_r;
   logic                  ld_res_r;
   logic [1:0]            mp_cnt;
   logic                  last_p;
   logic                  last_it;
   logic                  busy;

   assign last_p  = ({1'b0, p} + 1'b1) >= {1'b0, sh.acc_cfg.per};
   assign last_it = ({1'b0, it} + 1'b1) >= {1'b0, sh.acc_cfg.iter};

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         walking  <= 1'b0;
         p        <= '0;
         it       <= '0;
         ld_acc_r <= 1'b0;
         ld_res_r <= 1'b0;
         mp_cnt   <= '0;
      end else if (sh.start) begin
         walking  <= (sh.acc_cfg.iter != '0);
         p        <= '0;
         it       <= '0;
         ld_acc_r <= 1'b0;
         ld_res_r <= 1'b0;
         // two results to go before the first pool
         mp_cnt   <= 2'd2;
      end else begin
         ld_acc_r <= walking && (p == '0);
         ld_res_r <= ld_acc_r;
         if (ld_res) begin
            mp_cnt <= mp_cnt + 1'b1;
         end
         if (walking) begin
            if (!last_p) begin
               p <= p + 1'b1;
            end else begin
               p <= '0;
               if (last_it) begin
                  walking <= 1'b0;
               end else begin
                  it <= it + 1'b1;
               end
            end
         end
      end
   end

   // pipeline tail still counts as busy
   assign busy   = walking | ld_acc_r | ld_res_r;
   assign ld_acc = ld_acc_r;
   assign ld_res = ld_res_r | (sh.acc_cfg.bypass & busy);
   assign ld_mp  = sh.acc_cfg.maxpool & (mp_cnt != 2'd0) & busy;
   assign done   = ~busy;

endmodule

// ==== logic/wr_addrgen.sv ====
`timescale 1ns/100ps

module wr_addrgen (
   input  logic                                clk,
   input  logic                                rst,
   shadow_if.seq_sink                          sh,
   output logic [yolo_cfg_pkg::mem_addr_w-1:0] addr,
   output logic                                en,
   output logic                                done
);

   import yolo_cfg_pkg::*;

   typedef enum logic [1:0] {st_idle, st_delay, st_walk} state_t;

   state_t                state;
   logic [period_w-1:0]   dly_cnt;
   logic [period_w-1:0]   p;
   logic [mem_addr_w-1:0] it;
   logic [mem_addr_w-1:0] line;
   logic                  last_p;
   logic                  last_it;

   // zero period acts as one
   assign last_p  = ({1'b0, p} + 1'b1) >= {1'b0, sh.wr_cfg.per};
   assign last_it = ({1'b0, it} + 1'b1) >= {1'b0, sh.wr_cfg.iter};

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state   <= st_idle;
         dly_cnt <= '0;
         p       <= '0;
         it      <= '0;
         line    <= '0;
         addr    <= '0;
      end else if (sh.start) begin
         dly_cnt <= sh.wr_cfg.delay;
         p       <= '0;
         it      <= '0;
         line    <= sh.wr_cfg.start;
         addr    <= sh.wr_cfg.start;
         if (sh.wr_cfg.iter == '0) begin
            state <= st_idle;
         end else if (sh.wr_cfg.delay == '0) begin
            state <= st_walk;
         end else begin
            state <= st_delay;
         end
      end else begin
         case (state)
            st_delay: begin
               dly_cnt <= dly_cnt - 1'b1;
               if (dly_cnt == period_w'(1)) begin
                  state <= st_walk;
               end
            end
            st_walk: begin
               if (!last_p) begin
                  p    <= p + 1'b1;
                  addr <= addr + sh.wr_cfg.incr;
               end else begin
                  p <= '0;
                  if (last_it) begin
                     state <= st_idle;
                  end else begin
                     // next line
                     it   <= it + 1'b1;
                     line <= line + sh.wr_cfg.shift;
                     addr <= line + sh.wr_cfg.shift;
                  end
               end
            end
            default: ;
         endcase
      end
   end

   assign en   = (state == st_walk) && (p < sh.wr_cfg.duty);
   assign done = (state == st_idle);

endmodule

// ==== logic/ext_addr_calc.sv ====
`timescale 1ns/100ps

module ext_addr_calc (
   input  logic clk,
   input  logic rst,
   shadow_if.ext_sink sh,
   output logic [yolo_cfg_pkg::n_stages-1:0][yolo_cfg_pkg::io_addr_w-1:0] stage_ext_addr
);

   import yolo_cfg_pkg::*;

   logic [io_addr_w-1:0]               base_r;
   logic [n_stages-1:0][io_addr_w-1:0] prod;

   // multiply, then add the base one cycle later
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         base_r         <= '0;
         prod           <= '0;
         stage_ext_addr <= '0;
      end else begin
         base_r <= sh.ext_cfg.base;
         for (int i = 0; i < n_stages; i++) begin
            prod[i]           <= io_addr_w'(sh.ext_cfg.offset) * io_addr_w'(i);
            stage_ext_addr[i] <= base_r + prod[i];
         end
      end
   end

endmodule

// ==== logic/cfg_shadow.sv ====
`timescale 1ns/100ps

module cfg_shadow (
   input  logic                                clk,
   input  logic                                rst,
   input  logic                                run,
   input  yolo_types_pkg::ext_cfg_t            ext_cfg,
   input  logic [yolo_cfg_pkg::mem_addr_w-1:0] int_addr,
   input  yolo_types_pkg::wr_cfg_t             wr_cfg,
   input  yolo_types_pkg::acc_cfg_t            acc_cfg,
   shadow_if.src                               sh
);

   import yolo_cfg_pkg::*;
   import yolo_types_pkg::*;

   logic [mem_addr_w-1:0] int_pipe [shadow_depth];
   logic                  start_r;

   cfg_shadow_pipe #(.payload_t(ext_cfg_t)) u_ext_pipe (
      .clk  (clk),
      .rst  (rst),
      .step (run),
      .d    (ext_cfg),
      .q    (sh.ext_cfg)
   );

   cfg_shadow_pipe #(.payload_t(wr_cfg_t)) u_wr_pipe (
      .clk  (clk),
      .rst  (rst),
      .step (run),
      .d    (wr_cfg),
      .q    (sh.wr_cfg)
   );

   cfg_shadow_pipe #(.payload_t(acc_cfg_t)) u_acc_pipe (
      .clk  (clk),
      .rst  (rst),
      .step (run),
      .d    (acc_cfg),
      .q    (sh.acc_cfg)
   );

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         for (int i = 0; i < shadow_depth; i++) begin
            int_pipe[i] <= '0;
         end
         start_r <= 1'b0;
      end else begin
         start_r <= run;
         if (run) begin
            // swap buffer halves whenever the external side moves data
            int_pipe[0] <= {int_pipe[0][mem_addr_w-1] ^ (|ext_cfg.ext_iter),
                            int_addr[mem_addr_w-2:0]};
            for (int i = 1; i < shadow_depth; i++) begin
               int_pipe[i] <= int_pipe[i-1];
            end
         end
      end
   end

   assign sh.int_addr = int_pipe[shadow_depth-1];
   assign sh.start    = start_r;

endmodule

// ==== logic/cfg_shadow_pipe.sv ====
`timescale 1ns/100ps

module cfg_shadow_pipe #(
   parameter type payload_t = logic
) (
   input  logic     clk,
   input  logic     rst,
   input  logic     step,
   input  payload_t d,
   output payload_t q
);

   import yolo_cfg_pkg::*;

   payload_t stage [shadow_depth];

   // moves only on run
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         for (int i = 0; i < shadow_depth; i++) begin
            stage[i] <= '0;
         end
      end else if (step) begin
         stage[0] <= d;
         for (int i = 1; i < shadow_depth; i++) begin
            stage[i] <= stage[i-1];
         end
      end
   end

   assign q = stage[shadow_depth-1];

endmodule

// ==== logic/cfg_regs.sv ====
`timescale 1ns/100ps

module cfg_regs (
   input  logic                                clk,
   input  logic                                rst,
   input  logic                                clear,
   input  logic                                valid,
   input  logic                                wstrb,
   input  logic [yolo_cfg_pkg::cfg_addr_w-1:0] addr,
   input  logic [yolo_cfg_pkg::io_addr_w-1:0]  wdata,
   output yolo_types_pkg::ext_cfg_t            ext_cfg,
   output logic [yolo_cfg_pkg::mem_addr_w-1:0] int_addr,
   output yolo_types_pkg::wr_cfg_t             wr_cfg,
   output yolo_types_pkg::acc_cfg_t            acc_cfg
);

   import yolo_cfg_pkg::*;

   logic wr;

   // write needs valid and wstrb in the same cycle
   assign wr = valid & wstrb;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         ext_cfg  <= '0;
         int_addr <= '0;
         wr_cfg   <= '0;
         acc_cfg  <= '0;
      end else if (clear) begin
         ext_cfg  <= '0;
         int_addr <= '0;
         wr_cfg   <= '0;
         acc_cfg  <= '0;
      end else if (wr) begin
         case (addr)
            cfg_ext_base:
               ext_cfg.base <= wdata;
            cfg_ext_offset:
               ext_cfg.offset <= wdata[io_addr_w/2-1:0];
            cfg_ext_iter:
               ext_cfg.ext_iter <= wdata[mem_addr_w-1:0];
            cfg_int_addr:
               int_addr <= wdata[mem_addr_w-1:0];
            cfg_wr_start:
               wr_cfg.start <= wdata[mem_addr_w-1:0];
            cfg_wr_iter:
               wr_cfg.iter <= wdata[mem_addr_w-1:0];
            cfg_wr_per:
               wr_cfg.per <= wdata[period_w-1:0];
            cfg_wr_duty:
               wr_cfg.duty <= wdata[period_w-1:0];
            cfg_wr_shift:
               wr_cfg.shift <= wdata[mem_addr_w-1:0];
            cfg_wr_incr:
               wr_cfg.incr <= wdata[mem_addr_w-1:0];
            cfg_wr_delay:
               wr_cfg.delay <= wdata[period_w-1:0];
            cfg_acc_iter:
               acc_cfg.iter <= wdata[mem_addr_w-1:0];
            cfg_acc_per:
               acc_cfg.per <= wdata[period_w-1:0];
            cfg_acc_maxpool:
               acc_cfg.maxpool <= wdata[0];
            cfg_acc_bypass:
               acc_cfg.bypass <= wdata[0];
            default: ;
         endcase
      end
   end

endmodule

// ==== logic/shadow_if.sv ====
`timescale 1ns/100ps

interface shadow_if;

   import yolo_cfg_pkg::*;
   import yolo_types_pkg::*;

   ext_cfg_t              ext_cfg;
   wr_cfg_t               wr_cfg;
   acc_cfg_t              acc_cfg;
   logic [mem_addr_w-1:0] int_addr;
   // one cycle after run
   logic                  start;

   modport src (
      output ext_cfg,
      output wr_cfg,
      output acc_cfg,
      output int_addr,
      output start
   );

   modport ext_sink (input ext_cfg);

   modport seq_sink (input wr_cfg, input acc_cfg, input start);

endinterface

// ==== logic/yolo_types_pkg.sv ====
package yolo_types_pkg;

   import yolo_cfg_pkg::*;

   // external transfer set
   typedef struct packed {
      logic [io_addr_w-1:0]   base;
      logic [io_addr_w/2-1:0] offset;
      logic [mem_addr_w-1:0]  ext_iter;
   } ext_cfg_t;

   // internal write sequence
   typedef struct packed {
      logic [mem_addr_w-1:0] start;
      logic [mem_addr_w-1:0] iter;
      logic [mem_addr_w-1:0] shift;
      logic [mem_addr_w-1:0] incr;
      logic [period_w-1:0]   per;
      logic [period_w-1:0]   duty;
      logic [period_w-1:0]   delay;
   } wr_cfg_t;

   // accumulate and result load
   typedef struct packed {
      logic [mem_addr_w-1:0] iter;
      logic [period_w-1:0]   per;
      logic                  maxpool;
      logic                  bypass;
   } acc_cfg_t;

endpackage

// ==== logic/yolo_cfg_pkg.sv ====
package yolo_cfg_pkg;

   // widths
   localparam int io_addr_w  = 32;
   localparam int mem_addr_w = 10;
   localparam int period_w   = 10;
   localparam int cfg_addr_w = 5;

   localparam int n_stages = 4;

   // run pulses between a register write and its shadow copy
   localparam int shadow_depth = 2;

   // register map
   localparam logic [cfg_addr_w-1:0] cfg_ext_base    = 5'd0;
   localparam logic [cfg_addr_w-1:0] cfg_ext_offset  = 5'd1;
   localparam logic [cfg_addr_w-1:0] cfg_ext_iter    = 5'd2;
   localparam logic [cfg_addr_w-1:0] cfg_int_addr    = 5'd3;
   localparam logic [cfg_addr_w-1:0] cfg_wr_start    = 5'd4;
   localparam logic [cfg_addr_w-1:0] cfg_wr_iter     = 5'd5;
   localparam logic [cfg_addr_w-1:0] cfg_wr_per      = 5'd6;
   localparam logic [cfg_addr_w-1:0] cfg_wr_duty     = 5'd7;
   localparam logic [cfg_addr_w-1:0] cfg_wr_shift    = 5'd8;
   localparam logic [cfg_addr_w-1:0] cfg_wr_incr     = 5'd9;
   localparam logic [cfg_addr_w-1:0] cfg_wr_delay    = 5'd10;
   localparam logic [cfg_addr_w-1:0] cfg_acc_iter    = 5'd11;
   localparam logic [cfg_addr_w-1:0] cfg_acc_per     = 5'd12;
   localparam logic [cfg_addr_w-1:0] cfg_acc_maxpool = 5'd13;
   localparam logic [cfg_addr_w-1:0] cfg_acc_bypass  = 5'd14;

endpackage
